/* design/core_pkg.sv */
`default_nettype none

package core_pkg;

	// data path width, fixed by RV32I
	localparam int XLEN = 32;

	typedef logic [XLEN-1:0] word_t;
	typedef logic [4:0]      exe_fun_t;
	typedef logic [4:0]      reg_addr_t;
	typedef logic [4:0]      mem_wen_t;
	typedef logic [3:0]      wb_sel_t;
	typedef logic [2:0]      csr_cmd_t;

	// **********************************************************************
	// execute function codes, 0 is no operation
	// **********************************************************************

	localparam exe_fun_t EXE_NOP   = 5'd0;

	// alu
	localparam exe_fun_t ALU_ADD   = 5'd1;
	localparam exe_fun_t ALU_SUB   = 5'd2;
	localparam exe_fun_t ALU_AND   = 5'd3;
	localparam exe_fun_t ALU_OR    = 5'd4;
	localparam exe_fun_t ALU_XOR   = 5'd5;
	localparam exe_fun_t ALU_SLL   = 5'd6;
	localparam exe_fun_t ALU_SRL   = 5'd7;
	localparam exe_fun_t ALU_SRA   = 5'd8;
	localparam exe_fun_t ALU_SLT   = 5'd9;
	localparam exe_fun_t ALU_SLTU  = 5'd10;
	localparam exe_fun_t ALU_JALR  = 5'd11;
	localparam exe_fun_t ALU_COPY1 = 5'd12;

	// branch compare
	localparam exe_fun_t BR_BEQ    = 5'd13;
	localparam exe_fun_t BR_BNE    = 5'd14;
	localparam exe_fun_t BR_BLT    = 5'd15;
	localparam exe_fun_t BR_BGE    = 5'd16;
	localparam exe_fun_t BR_BLTU   = 5'd17;
	localparam exe_fun_t BR_BGEU   = 5'd18;

endpackage

`default_nettype wire

/* design/ex_alu.sv */
`default_nettype none

module ex_alu (
	ex_op_if.sink                op,
	output core_pkg::word_t      alu_result
);
	import core_pkg::*;

	word_t    sum;
	logic [4:0] shamt;

	assign sum   = op.op1 + op.op2;
	// only the low five bits shift
	assign shamt = op.op2[4:0];

	always_comb begin
		case (op.exe_fun)
			ALU_ADD: begin
				alu_result = sum;
			end
			ALU_SUB: begin
				alu_result = op.op1 - op.op2;
			end
			ALU_AND: begin
				alu_result = op.op1 & op.op2;
			end
			ALU_OR: begin
				alu_result = op.op1 | op.op2;
			end
			ALU_XOR: begin
				alu_result = op.op1 ^ op.op2;
			end
			ALU_SLL: begin
				alu_result = op.op1 << shamt;
			end
			ALU_SRL: begin
				alu_result = op.op1 >> shamt;
			end
			ALU_SRA: begin
				alu_result = word_t'($signed(op.op1) >>> shamt);
			end
			ALU_SLT: begin
				alu_result = word_t'($signed(op.op1) < $signed(op.op2));
			end
			ALU_SLTU: begin
				alu_result = word_t'(op.op1 < op.op2);
			end
			// jalr target, bit 0 dropped
			ALU_JALR: begin
				alu_result = sum & ~word_t'(1);
			end
			ALU_COPY1: begin
				alu_result = op.op1;
			end
			// branches and unused codes
			default: begin
				alu_result = '0;
			end
		endcase
	end

endmodule

`default_nettype wire

/* design/ex_branch_unit.sv */
`default_nettype none

module ex_branch_unit (
	ex_op_if.sink                op,
	output logic                 br_taken,
	output core_pkg::word_t      br_dest
);
	import core_pkg::*;

	logic eq;
	logic lt_s;
	logic lt_u;

	assign eq   = op.op1 == op.op2;
	assign lt_s = $signed(op.op1) < $signed(op.op2);
	assign lt_u = op.op1 < op.op2;

	always_comb begin
		case (op.exe_fun)
			BR_BEQ:  br_taken = eq;
			BR_BNE:  br_taken = !eq;
			BR_BLT:  br_taken = lt_s;
			BR_BGE:  br_taken = !lt_s;
			BR_BLTU: br_taken = lt_u;
			BR_BGEU: br_taken = !lt_u;
			// not a branch
			default: br_taken = 1'b0;
		endcase
	end

	// target computed for every op, used only when taken
	assign br_dest = op.pc + op.imm_b;

endmodule

`default_nettype wire

/* design/ex_issue_latch.sv */
`default_nettype none

module ex_issue_latch (
	input  wire logic               clk,
	input  wire logic               rst_n,
	input  wire logic               stall,
	input  wire core_pkg::word_t     id_pc,
	input  wire core_pkg::exe_fun_t  id_exe_fun,
	input  wire core_pkg::word_t     id_op1,
	input  wire core_pkg::word_t     id_op2,
	input  wire core_pkg::word_t     id_rs2,
	input  wire core_pkg::word_t     id_imm_i,
	input  wire core_pkg::word_t     id_imm_b,
	input  wire core_pkg::mem_wen_t  id_mem_wen,
	input  wire logic               id_rf_wen,
	input  wire core_pkg::wb_sel_t   id_wb_sel,
	input  wire core_pkg::reg_addr_t id_wb_addr,
	input  wire core_pkg::csr_cmd_t  id_csr_cmd,
	input  wire logic               id_jmp_flg,
	input  wire logic               id_ecall,
	ex_op_if.source                 op
);
	import core_pkg::*;

	word_t     save_pc;
	exe_fun_t  save_exe_fun;
	word_t     save_op1;
	word_t     save_op2;
	word_t     save_rs2;
	word_t     save_imm_i;
	word_t     save_imm_b;
	mem_wen_t  save_mem_wen;
	logic      save_rf_wen;
	wb_sel_t   save_wb_sel;
	reg_addr_t save_wb_addr;
	csr_cmd_t  save_csr_cmd;
	logic      save_jmp_flg;
	logic      save_ecall;

	// replay the saved operation while stalled
	assign op.pc      = stall ? save_pc      : id_pc;
	assign op.exe_fun = stall ? save_exe_fun : id_exe_fun;
	assign op.op1     = stall ? save_op1     : id_op1;
	assign op.op2     = stall ? save_op2     : id_op2;
	assign op.rs2     = stall ? save_rs2     : id_rs2;
	assign op.imm_i   = stall ? save_imm_i   : id_imm_i;
	assign op.imm_b   = stall ? save_imm_b   : id_imm_b;
	assign op.mem_wen = stall ? save_mem_wen : id_mem_wen;
	assign op.rf_wen  = stall ? save_rf_wen  : id_rf_wen;
	assign op.wb_sel  = stall ? save_wb_sel  : id_wb_sel;
	assign op.wb_addr = stall ? save_wb_addr : id_wb_addr;
	assign op.csr_cmd = stall ? save_csr_cmd : id_csr_cmd;
	assign op.jmp_flg = stall ? save_jmp_flg : id_jmp_flg;
	assign op.ecall   = stall ? save_ecall   : id_ecall;

	// zero copy after reset, so an early stall replays a nop
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			save_pc      <= '0;
			save_exe_fun <= EXE_NOP;
			save_op1     <= '0;
			save_op2     <= '0;
			save_rs2     <= '0;
			save_imm_i   <= '0;
			save_imm_b   <= '0;
			save_mem_wen <= '0;
			save_rf_wen  <= 1'b0;
			save_wb_sel  <= '0;
			save_wb_addr <= '0;
			save_csr_cmd <= '0;
			save_jmp_flg <= 1'b0;
			save_ecall   <= 1'b0;
		end else begin
			save_pc      <= op.pc;
			save_exe_fun <= op.exe_fun;
			save_op1     <= op.op1;
			save_op2     <= op.op2;
			save_rs2     <= op.rs2;
			save_imm_i   <= op.imm_i;
			save_imm_b   <= op.imm_b;
			save_mem_wen <= op.mem_wen;
			save_rf_wen  <= op.rf_wen;
			save_wb_sel  <= op.wb_sel;
			save_wb_addr <= op.wb_addr;
			save_csr_cmd <= op.csr_cmd;
			save_jmp_flg <= op.jmp_flg;
			save_ecall   <= op.ecall;
		end
	end

	a_stall_known: assert property (@(posedge clk) disable iff (!rst_n) !$isunknown(stall));

endmodule

`default_nettype wire

/* design/ex_mem_latch.sv */
`default_nettype none

module ex_mem_latch (
	input  wire logic               clk,
	input  wire logic               rst_n,
	ex_op_if.sink                   op,
	input  wire core_pkg::word_t     alu_result,
	input  wire core_pkg::word_t     br_dest,
	input  wire logic               br_taken,
	output core_pkg::word_t          alu_out,
	output logic                    br_flg,
	output core_pkg::word_t          br_target,
	output core_pkg::word_t          mem_pc,
	output core_pkg::word_t          mem_rs2,
	output core_pkg::word_t          mem_op1,
	output core_pkg::word_t          mem_imm_i,
	output core_pkg::mem_wen_t       mem_mem_wen,
	output logic                    mem_rf_wen,
	output core_pkg::wb_sel_t        mem_wb_sel,
	output core_pkg::reg_addr_t      mem_wb_addr,
	output core_pkg::csr_cmd_t       mem_csr_cmd,
	output logic                    mem_jmp_flg,
	output logic                    mem_ecall
);
	import core_pkg::*;

	logic is_branch;

	assign is_branch = op.exe_fun inside {BR_BEQ, BR_BNE, BR_BLT, BR_BGE, BR_BLTU, BR_BGEU};

	// **********************************************************************
	// EX/MEM register
	// **********************************************************************

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			alu_out     <= '0;
			br_flg      <= 1'b0;
			br_target   <= '0;
			mem_pc      <= '0;
			mem_rs2     <= '0;
			mem_op1     <= '0;
			mem_imm_i   <= '0;
			mem_mem_wen <= '0;
			mem_rf_wen  <= 1'b0;
			mem_wb_sel  <= '0;
			mem_wb_addr <= '0;
			mem_csr_cmd <= '0;
			mem_jmp_flg <= 1'b0;
			mem_ecall   <= 1'b0;
		end else begin
			alu_out     <= alu_result;
			br_flg      <= br_taken;
			br_target   <= br_dest;
			mem_pc      <= op.pc;
			mem_rs2     <= op.rs2;
			mem_op1     <= op.op1;
			mem_imm_i   <= op.imm_i;
			mem_mem_wen <= op.mem_wen;
			mem_rf_wen  <= op.rf_wen;
			mem_wb_sel  <= op.wb_sel;
			mem_wb_addr <= op.wb_addr;
			mem_csr_cmd <= op.csr_cmd;
			mem_jmp_flg <= op.jmp_flg;
			mem_ecall   <= op.ecall;
		end
	end

	// a taken flag must come from a branch code one cycle earlier
	a_br_flg_only_branch: assert property (
		@(posedge clk) disable iff (!rst_n) !is_branch |=> !br_flg
	);

endmodule

`default_nettype wire

/* design/ex_op_if.sv */
`default_nettype none

// one decoded operation as seen by the execute stage
interface ex_op_if;
	import core_pkg::*;

	word_t     pc;
	exe_fun_t  exe_fun;
	word_t     op1;
	word_t     op2;
	word_t     rs2;
	word_t     imm_i;
	word_t     imm_b;

	// carried on toward memory and writeback
	mem_wen_t  mem_wen;
	logic      rf_wen;
	wb_sel_t   wb_sel;
	reg_addr_t wb_addr;
	csr_cmd_t  csr_cmd;
	logic      jmp_flg;
	logic      ecall;

	modport source (
		output pc, exe_fun, op1, op2, rs2, imm_i, imm_b,
		output mem_wen, rf_wen, wb_sel, wb_addr, csr_cmd, jmp_flg, ecall
	);

	modport sink (
		input pc, exe_fun, op1, op2, rs2, imm_i, imm_b,
		input mem_wen, rf_wen, wb_sel, wb_addr, csr_cmd, jmp_flg, ecall
	);

endinterface

`default_nettype wire

/* design/ex_stage.sv */
`default_nettype none

module ex_stage (
	input  wire logic               clk,
	input  wire logic               rst_n,
	input  wire logic               stall,
	input  wire core_pkg::word_t     id_pc,
	input  wire core_pkg::exe_fun_t  id_exe_fun,
	input  wire core_pkg::word_t     id_op1,
	input  wire core_pkg::word_t     id_op2,
	input  wire core_pkg::word_t     id_rs2,
	input  wire core_pkg::word_t     id_imm_i,
	input  wire core_pkg::word_t     id_imm_b,
	input  wire core_pkg::mem_wen_t  id_mem_wen,
	input  wire logic               id_rf_wen,
	input  wire core_pkg::wb_sel_t   id_wb_sel,
	input  wire core_pkg::reg_addr_t id_wb_addr,
	input  wire core_pkg::csr_cmd_t  id_csr_cmd,
	input  wire logic               id_jmp_flg,
	input  wire logic               id_ecall,
	output core_pkg::word_t          alu_out,
	output logic                    br_flg,
	output core_pkg::word_t          br_target,
	output core_pkg::word_t          mem_pc,
	output core_pkg::word_t          mem_rs2,
	output core_pkg::word_t          mem_op1,
	output core_pkg::word_t          mem_imm_i,
	output core_pkg::mem_wen_t       mem_mem_wen,
	output logic                    mem_rf_wen,
	output core_pkg::wb_sel_t        mem_wb_sel,
	output core_pkg::reg_addr_t      mem_wb_addr,
	output core_pkg::csr_cmd_t       mem_csr_cmd,
	output logic                    mem_jmp_flg,
	output logic                    mem_ecall
);
	import core_pkg::*;

	word_t alu_result;
	word_t br_dest;
	logic  br_taken;

	// selected operation, shared by all consumers
	ex_op_if op_bus ();

	ex_issue_latch ex_issue_latch_inst (
		.clk, .rst_n, .stall,
		.id_pc, .id_exe_fun, .id_op1, .id_op2, .id_rs2, .id_imm_i, .id_imm_b,
		.id_mem_wen, .id_rf_wen, .id_wb_sel, .id_wb_addr, .id_csr_cmd,
		.id_jmp_flg, .id_ecall,
		.op (op_bus.source)
	);

	ex_alu ex_alu_inst (
		.op         (op_bus.sink),
		.alu_result (alu_result)
	);

	ex_branch_unit ex_branch_unit_inst (
		.op       (op_bus.sink),
		.br_taken (br_taken),
		.br_dest  (br_dest)
	);

	ex_mem_latch ex_mem_latch_inst (
		.clk, .rst_n,
		.op (op_bus.sink),
		.alu_result, .br_dest, .br_taken,
		.alu_out, .br_flg, .br_target,
		.mem_pc, .mem_rs2, .mem_op1, .mem_imm_i,
		.mem_mem_wen, .mem_rf_wen, .mem_wb_sel, .mem_wb_addr,
		.mem_csr_cmd, .mem_jmp_flg, .mem_ecall
	);

endmodule

`default_nettype wire

/* run.sh */
#!/bin/sh
cd "$(dirname "$0")" || exit 1

verilator --binary --assert -f verilog.f --top-module ex_stage_tb -o ex_stage_tb_sim || exit 1

out=$(./obj_dir/ex_stage_tb_sim)
echo "$out"

echo "$out" | grep -q "^Simulation finished: PASS$" && exit 0 || exit 1

/* test/ex_model.svh */
`ifndef EX_MODEL_SVH
`define EX_MODEL_SVH

// two's complement less-than on raw words
function automatic logic signed_less(input word_t a, input word_t b);
	if (a[31] != b[31])
		return a[31];
	return a < b;
endfunction

function automatic word_t model_alu(input exe_fun_t fun, input word_t a, input word_t b);
	word_t       r;
	int unsigned sh;
	sh = b % 32;
	r  = '0;
	case (fun)
		ALU_ADD:   r = a + b;
		ALU_SUB:   r = a + ~b + 32'd1;
		ALU_AND:   r = a & b;
		ALU_OR:    r = a | b;
		ALU_XOR:   r = a ^ b;
		ALU_SLL:   r = a << sh;
		ALU_SRL:   r = a >> sh;
		// fill vacated bits with the sign
		ALU_SRA:   r = a[31] ? ((a >> sh) | ~(32'hffff_ffff >> sh)) : (a >> sh);
		ALU_SLT:   r = {31'b0, signed_less(a, b)};
		ALU_SLTU:  r = {31'b0, a < b};
		ALU_JALR:  r = (a + b) & 32'hffff_fffe;
		ALU_COPY1: r = a;
		default:   r = '0;
	endcase
	return r;
endfunction

function automatic logic model_branch(input exe_fun_t fun, input word_t a, input word_t b);
	case (fun)
		BR_BEQ:  return a == b;
		BR_BNE:  return a != b;
		BR_BLT:  return signed_less(a, b);
		BR_BGE:  return !signed_less(a, b);
		BR_BLTU: return a < b;
		BR_BGEU: return !(a < b);
		default: return 1'b0;
	endcase
endfunction

// branch target for any code
function automatic word_t model_target(input word_t pc, input word_t offset);
	return pc + offset;
endfunction

`endif

/* test/ex_stage_tb.sv */
`default_nettype none

module ex_stage_tb;
	import core_pkg::*;

	localparam int          NUM_OPS      = 2000;
	localparam int          RESET_CYCLES = 10;
	localparam int          CYCLE_LIMIT  = 2100;
	localparam logic [31:0] SEED         = 32'h356f7bc9;

	typedef struct packed {
		word_t     pc;
		exe_fun_t  exe_fun;
		word_t     op1;
		word_t     op2;
		word_t     rs2;
		word_t     imm_i;
		word_t     imm_b;
		mem_wen_t  mem_wen;
		logic      rf_wen;
		wb_sel_t   wb_sel;
		reg_addr_t wb_addr;
		csr_cmd_t  csr_cmd;
		logic      jmp_flg;
		logic      ecall;
	} op_t;

	logic      clk;
	logic      rst_n;
	logic      stall;
	word_t     id_pc, id_op1, id_op2, id_rs2, id_imm_i, id_imm_b;
	exe_fun_t  id_exe_fun;
	mem_wen_t  id_mem_wen;
	logic      id_rf_wen, id_jmp_flg, id_ecall;
	wb_sel_t   id_wb_sel;
	reg_addr_t id_wb_addr;
	csr_cmd_t  id_csr_cmd;
	word_t     alu_out, br_target, mem_pc, mem_rs2, mem_op1, mem_imm_i;
	logic      br_flg, mem_rf_wen, mem_jmp_flg, mem_ecall;
	mem_wen_t  mem_mem_wen;
	wb_sel_t   mem_wb_sel;
	reg_addr_t mem_wb_addr;
	csr_cmd_t  mem_csr_cmd;

	logic [31:0] rng_state;
	int          cycle_count = 0;

	`include "ex_model.svh"

	ex_stage ex_stage_inst (.*);

	initial begin
		clk = 1'b0;
		forever #5 clk = ~clk;
	end

	always @(posedge clk) begin
		cycle_count <= cycle_count + 1;
		if (cycle_count >= CYCLE_LIMIT) begin
			$display("run timed out after %0d cycles without finishing the test", cycle_count);
			$display("Simulation finished: FAIL");
			$fatal(1, "timeout");
		end
	end

	// **********************************************************************
	// stimulus and checking helpers
	// **********************************************************************

	function automatic logic [31:0] xorshift32(input logic [31:0] x);
		x = x ^ (x << 13);
		x = x ^ (x >> 17);
		x = x ^ (x << 5);
		return x;
	endfunction

	task automatic next_random(output logic [31:0] r);
		rng_state = xorshift32(rng_state);
		r = rng_state;
	endtask

	task automatic check_value(input string name, input logic [31:0] expected,
			input logic [31:0] actual);
		if (actual !== expected) begin
			$display("** Error at %0t: %s expected %h actual %h", $time, name, expected, actual);
			$display("Simulation finished: FAIL");
			$fatal(1, "stopping at first mismatch");
		end
	endtask

	task automatic check_outputs(input op_t e);
		check_value("alu_out", model_alu(e.exe_fun, e.op1, e.op2), alu_out);
		check_value("br_flg", 32'(model_branch(e.exe_fun, e.op1, e.op2)), 32'(br_flg));
		check_value("br_target", model_target(e.pc, e.imm_b), br_target);
		check_value("mem_pc", e.pc, mem_pc);
		check_value("mem_rs2", e.rs2, mem_rs2);
		check_value("mem_op1", e.op1, mem_op1);
		check_value("mem_imm_i", e.imm_i, mem_imm_i);
		check_value("mem_mem_wen", 32'(e.mem_wen), 32'(mem_mem_wen));
		check_value("mem_rf_wen", 32'(e.rf_wen), 32'(mem_rf_wen));
		check_value("mem_wb_sel", 32'(e.wb_sel), 32'(mem_wb_sel));
		check_value("mem_wb_addr", 32'(e.wb_addr), 32'(mem_wb_addr));
		check_value("mem_csr_cmd", 32'(e.csr_cmd), 32'(mem_csr_cmd));
		check_value("mem_jmp_flg", 32'(e.jmp_flg), 32'(mem_jmp_flg));
		check_value("mem_ecall", 32'(e.ecall), 32'(mem_ecall));
	endtask

	task automatic random_op(output op_t o);
		logic [31:0] r;
		next_random(r);
		o.exe_fun = exe_fun_t'(r % 21);
		next_random(r);
		o.op1 = r;
		next_random(r);
		o.op2 = r;
		// equal operands now and then for beq and bge
		next_random(r);
		if (r[2:0] == 3'd0)
			o.op2 = o.op1;
		next_random(r);
		o.pc = r;
		next_random(r);
		o.rs2 = r;
		next_random(r);
		o.imm_i = r;
		next_random(r);
		o.imm_b = r;
		next_random(r);
		o.mem_wen = r[4:0];
		o.rf_wen  = r[5];
		o.wb_sel  = r[9:6];
		o.wb_addr = r[14:10];
		o.csr_cmd = r[17:15];
		o.jmp_flg = r[18];
		o.ecall   = r[19];
	endtask

	task automatic drive_inputs(input op_t o);
		id_pc      = o.pc;
		id_exe_fun = o.exe_fun;
		id_op1     = o.op1;
		id_op2     = o.op2;
		id_rs2     = o.rs2;
		id_imm_i   = o.imm_i;
		id_imm_b   = o.imm_b;
		id_mem_wen = o.mem_wen;
		id_rf_wen  = o.rf_wen;
		id_wb_sel  = o.wb_sel;
		id_wb_addr = o.wb_addr;
		id_csr_cmd = o.csr_cmd;
		id_jmp_flg = o.jmp_flg;
		id_ecall   = o.ecall;
	endtask

	// **********************************************************************
	// main sequence
	// **********************************************************************

	initial begin
		op_t         live;
		op_t         saved;
		op_t         expected;
		logic [31:0] r;
		rng_state = SEED;
		rst_n     = 1'b0;
		stall     = 1'b0;
		saved     = '0;
		expected  = '0;
		drive_inputs('0);

		repeat (RESET_CYCLES) begin
			@(negedge clk);
			check_outputs('0);
		end
		@(negedge clk);
		check_outputs('0);

		// first cycle out of reset is stalled and replays a nop
		rst_n = 1'b1;
		stall = 1'b1;
		random_op(live);
		drive_inputs(live);
		expected = saved;

		for (int i = 0; i < NUM_OPS; i++) begin
			@(negedge clk);
			check_outputs(expected);
			random_op(live);
			next_random(r);
			stall = (r[1:0] == 2'd0);
			drive_inputs(live);
			if (!stall)
				saved = live;
			expected = saved;
		end
		@(negedge clk);
		check_outputs(expected);

		$display("Simulation finished: PASS");
		$finish;
	end

endmodule

`default_nettype wire

/* verilog.f */
+incdir+test
design/core_pkg.sv
design/ex_op_if.sv
design/ex_issue_latch.sv
design/ex_alu.sv
design/ex_branch_unit.sv
design/ex_mem_latch.sv
design/ex_stage.sv
test/ex_stage_tb.sv
